// File: flist.f
+incdir+design
design/pipe_pkg.sv
design/pipe_stage_reg.sv
design/fetch_unit.sv
design/decode_unit.sv
design/execute_unit.sv
design/memory_unit.sv
design/retire_trace_unit.sv
design/mini_pipe_top.sv
bench/mini_pipe_props.sv
bench/mini_pipe_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := mini_pipe_tb
FLIST     := flist.f
FLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
RUN_ARGS  := +verilator+error+limit+100
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Testbench passed
SOURCES   := $(FLIST) $(wildcard design/*.sv design/*.svh bench/*.sv)

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: $(OBJ_DIR)/V$(TOP)
	$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/mini_pipe_tb.sv
////////////////////////////////////////////////////////////////////////////
// Mini pipeline testbench
// Directed then random programs through the pipeline, each trace record
// compared with a reference model run on the accepted words
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "pipe_macros.svh"

module mini_pipe_tb;

    localparam int AW       = $clog2(`PIPE_DMEM_DEPTH);
    localparam int N_RANDOM = 300;

    logic                  clk;
    logic                  rst_n;
    logic                  in_valid;
    logic                  in_ready;
    logic [`PIPE_ILEN-1:0] in_word;
    logic                  trace_valid;
    logic                  trace_ready;
    pipe_pkg::trace_rec_t  trace_rec;

    integer                 seed;
    pipe_pkg::data_t        m_regs [`PIPE_NREGS];       // Model register file
    pipe_pkg::data_t        m_mem  [`PIPE_DMEM_DEPTH];  // Model data memory
    pipe_pkg::seq_t         m_seq;
    logic [`PIPE_NREGS-1:0] w_hist [3];                 // Writes of the last three, newest first
    logic                   stall_chk;                  // Stall rules apply to this phase
    logic [`PIPE_ILEN-1:0]  prog   [$];
    pipe_pkg::trace_rec_t   exp_q  [$];
    int                     kind_q [$];                 // 1 stall expected, 2 none expected

    mini_pipe_top mini_pipe_top_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_word     (in_word),
        .trace_valid (trace_valid),
        .trace_ready (trace_ready),
        .trace_rec   (trace_rec)
    );

    bind mini_pipe_top mini_pipe_props props_i (
        .clk (clk), .rst_n (rst_n), .in_ready (in_ready),
        .trace_valid (trace_valid), .trace_ready (trace_ready), .trace_rec (trace_rec)
    );

    always #5 clk = ~clk;

    // Stop on the first protocol property failure
    always @(posedge clk) begin
        if (mini_pipe_top_i.props_i.fail_cnt != 0) begin
            $display("protocol property failed before %0t", $time);
            abort_run();
        end
    end

    function automatic logic [`PIPE_ILEN-1:0] make_word(input logic [3:0] op,
            input logic [2:0] rd, input logic [2:0] rs1, input logic [5:0] lo);
        return {op, rd, rs1, lo};
    endfunction

    function automatic logic [`PIPE_NREGS-1:0] reg_bit(input logic [2:0] r);
        return (r == 3'd0) ? '0 : `PIPE_NREGS'(1) << r;  // r0 is never owed
    endfunction

    task automatic abort_run();
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic compare_field(input string name, input logic [15:0] got,
                                 input logic [15:0] want);
        assert (got === want) else begin
            $display("error: %s is %h, expected %h", name, got, want);
            abort_run();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Reference model, one call per accepted word, in program order
    ////////////////////////////////////////////////////////////////////////////

    task automatic model_accept(input logic [`PIPE_ILEN-1:0] w);
        logic [2:0]             rd;
        logic [2:0]             rs1;
        pipe_pkg::data_t        a, imm, addr, res;
        logic                   wr;
        logic [`PIPE_NREGS-1:0] rmask, wmask;
        int                     kind;
        rd    = w[11:9];
        rs1   = w[8:6];
        a     = m_regs[rs1];
        imm   = {{(`PIPE_XLEN-6){w[5]}}, w[5:0]};   // Signed 6-bit immediate
        addr  = (a + imm) & pipe_pkg::data_t'(`PIPE_DMEM_DEPTH - 1);
        res   = '0;
        wr    = 1'b0;
        rmask = '0;
        case (w[15:12])
            pipe_pkg::OP_ADD, pipe_pkg::OP_SUB, pipe_pkg::OP_XOR: begin
                if (w[15:12] == pipe_pkg::OP_ADD) res = a + m_regs[w[2:0]];
                else if (w[15:12] == pipe_pkg::OP_SUB) res = a - m_regs[w[2:0]];
                else res = a ^ m_regs[w[2:0]];
                wr    = 1'b1;
                rmask = reg_bit(rs1) | reg_bit(w[2:0]);
            end
            pipe_pkg::OP_ADDI: begin
                res   = a + imm;
                wr    = 1'b1;
                rmask = reg_bit(rs1);
            end
            pipe_pkg::OP_LOAD: begin
                res   = m_mem[addr[AW-1:0]];
                wr    = 1'b1;
                rmask = reg_bit(rs1);
            end
            pipe_pkg::OP_STORE: begin
                m_mem[addr[AW-1:0]] = m_regs[rd];       // Data comes from rd
                res   = addr;
                rmask = reg_bit(rs1) | reg_bit(rd);
            end
            default: ;
        endcase
        wr    = wr && (rd != 3'd0);
        wmask = wr ? reg_bit(rd) : '0;
        if (wr) m_regs[rd] = res;
        kind = 0;
        if (stall_chk) begin
            if ((rmask & w_hist[0]) != '0) kind = 1;  // Reads what the one before writes
            else if (((rmask | wmask) & (w_hist[0] | w_hist[1] | w_hist[2])) == '0) kind = 2;
        end
        w_hist[2] = w_hist[1];
        w_hist[1] = w_hist[0];
        w_hist[0] = wmask;
        exp_q.push_back('{seq: m_seq, pc: pipe_pkg::pc_t'(m_seq),
                          opcode: pipe_pkg::opcode_e'(w[15:12]), rd: rd, result: res,
                          wrote: wr, stall_cnt: '0});
        kind_q.push_back(kind);
        m_seq = m_seq + pipe_pkg::seq_t'(1);
    endtask

    task automatic check_record();
        pipe_pkg::trace_rec_t e;
        int                   kind;
        if (exp_q.size() == 0) begin
            $display("trace record with seq %h arrived with nothing outstanding", trace_rec.seq);
            abort_run();
        end
        e    = exp_q.pop_front();
        kind = kind_q.pop_front();
        compare_field("trace_rec.seq", 16'(trace_rec.seq), 16'(e.seq));
        compare_field("trace_rec.pc", 16'(trace_rec.pc), 16'(e.pc));
        compare_field("trace_rec.opcode", 16'(trace_rec.opcode), 16'(e.opcode));
        compare_field("trace_rec.rd", 16'(trace_rec.rd), 16'(e.rd));
        compare_field("trace_rec.result", trace_rec.result, e.result);
        compare_field("trace_rec.wrote", 16'(trace_rec.wrote), 16'(e.wrote));
        if (kind == 1) begin
            assert (trace_rec.stall_cnt != '0) else begin
                $display("error: trace_rec.stall_cnt is %h, expected nonzero",
                         trace_rec.stall_cnt);
                abort_run();
            end
        end
        if (kind == 2) compare_field("trace_rec.stall_cnt", 16'(trace_rec.stall_cnt), 16'h0);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Runs prog through the DUT until every record is back
    ////////////////////////////////////////////////////////////////////////////

    task automatic run_phase(input logic gaps, input logic bp);
        int          idx;
        int          cyc;
        int          limit;
        logic        took;
        logic [31:0] r;
        idx   = 0;
        cyc   = 0;
        limit = 40 * prog.size() + 200;
        while (idx < prog.size() || exp_q.size() != 0) begin
            @(posedge clk);
            took = in_valid && in_ready;
            if (took) begin
                model_accept(in_word);
                idx++;
            end
            if (trace_valid && trace_ready) check_record();
            cyc++;
            if (cyc > limit) begin
                $display("timeout with %0d of %0d words taken and %0d records missing",
                         idx, prog.size(), exp_q.size());
                abort_run();
            end
            #1;
            r = $random(seed);
            if (took || !in_valid) begin               // Offer holds until taken
                if (idx < prog.size() && (!gaps || r[1:0] != 2'b00)) begin
                    in_valid = 1'b1;
                    in_word  = prog[idx];
                end else begin
                    in_valid = 1'b0;
                end
            end
            trace_ready = bp ? r[5] : 1'b1;
        end
    endtask

    initial begin
        logic [31:0] r;
        logic [2:0]  op;
        seed        = 32'h1a359f72;
        clk         = 1'b0;
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        in_word     = '0;
        trace_ready = 1'b0;
        m_seq       = '0;
        stall_chk   = 1'b1;
        for (int i = 0; i < `PIPE_NREGS; i++) m_regs[i] = '0;
        for (int i = 0; i < `PIPE_DMEM_DEPTH; i++) m_mem[i] = '0;
        for (int i = 0; i < 3; i++) w_hist[i] = '0;
        repeat (8) @(posedge clk);
        #1;
        rst_n       = 1'b1;
        trace_ready = 1'b1;

        // Directed program, continuous input and no back-pressure
        prog.push_back(make_word(pipe_pkg::OP_ADDI,  3'd1, 3'd0, 6'd5));
        prog.push_back(make_word(pipe_pkg::OP_ADDI,  3'd2, 3'd0, 6'h3d));  // r2 = -3
        prog.push_back(make_word(pipe_pkg::OP_ADD,   3'd3, 3'd1, 6'd2));   // Needs r2 now
        prog.push_back(make_word(pipe_pkg::OP_ADDI,  3'd0, 3'd1, 6'd7));   // Lost write to r0
        prog.push_back(make_word(pipe_pkg::OP_ADD,   3'd4, 3'd0, 6'd1));   // r0 reads zero
        prog.push_back(make_word(pipe_pkg::OP_XOR,   3'd5, 3'd3, 6'd4));
        prog.push_back(make_word(pipe_pkg::OP_SUB,   3'd6, 3'd5, 6'd1));
        prog.push_back(make_word(pipe_pkg::OP_STORE, 3'd6, 3'd1, 6'd2));   // mem[7] = r6
        prog.push_back(make_word(pipe_pkg::OP_NOP,   3'd0, 3'd0, 6'd0));
        prog.push_back(make_word(pipe_pkg::OP_LOAD,  3'd7, 3'd0, 6'd7));   // Reads mem[7] back
        prog.push_back(make_word(pipe_pkg::OP_SUB,   3'd2, 3'd7, 6'd0));
        prog.push_back(make_word(pipe_pkg::OP_NOP,   3'd0, 3'd0, 6'd0));
        prog.push_back(make_word(pipe_pkg::OP_NOP,   3'd0, 3'd0, 6'd0));
        prog.push_back(make_word(pipe_pkg::OP_XOR,   3'd3, 3'd1, 6'd1));   // Clear of hazards
        prog.push_back(make_word(pipe_pkg::OP_ADDI,  3'd3, 3'd3, 6'h3f));
        run_phase(1'b0, 1'b0);

        // Random program with input gaps and random back-pressure
        prog.delete();
        stall_chk = 1'b0;
        for (int i = 0; i < N_RANDOM; i++) begin
            r  = $random(seed);
            op = r[18:16];
            if (op == 3'd7) op = 3'd0;                 // Defined opcodes only
            prog.push_back({1'b0, op, r[11:0]});
        end
        run_phase(1'b1, 1'b1);

        // Nothing may follow the last record
        repeat (10) begin
            @(posedge clk);
            assert (!trace_valid) else begin
                $display("extra trace record with seq %h after the last word", trace_rec.seq);
                abort_run();
            end
        end

        if (mini_pipe_top_i.props_i.fail_cnt != 0) begin
            $display("%0d protocol property failures", mini_pipe_top_i.props_i.fail_cnt);
            $display("Testbench failed");
            $fatal(1);
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

// File: bench/mini_pipe_props.sv
////////////////////////////////////////////////////////////////////////////
// Mini pipeline protocol properties
// Bound to the top, watches reset behavior and the trace output stream
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mini_pipe_props (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 in_ready,
    input logic                 trace_valid,
    input logic                 trace_ready,
    input pipe_pkg::trace_rec_t trace_rec
);

    int unsigned    fail_cnt;   // Failed property count, read by the testbench
    logic           have_rec;   // At least one record taken since reset
    pipe_pkg::seq_t last_seq;   // Seq of the last record taken

    initial fail_cnt = 0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            have_rec <= 1'b0;
        end else if (trace_valid && trace_ready) begin
            have_rec <= 1'b1;
            last_seq <= trace_rec.seq;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reset
    ////////////////////////////////////////////////////////////////////////////

    reset_quiet: assert property (@(posedge clk) !rst_n |=> !trace_valid)
        else begin
            fail_cnt++;
            $error("trace_valid high after a reset cycle");
        end

    // Input stays closed on the first cycle out of reset
    ready_late: assert property (@(posedge clk) $rose(rst_n) |-> !in_ready)
        else begin
            fail_cnt++;
            $error("in_ready high on the first cycle after reset");
        end

    ////////////////////////////////////////////////////////////////////////////
    // Trace stream
    ////////////////////////////////////////////////////////////////////////////

    rec_hold: assert property (@(posedge clk) disable iff (!rst_n)
        trace_valid && !trace_ready |=> trace_valid && $stable(trace_rec))
        else begin
            fail_cnt++;
            $error("trace record changed or dropped while trace_ready was low");
        end

    seq_step: assert property (@(posedge clk) disable iff (!rst_n)
        trace_valid && trace_ready && have_rec
            |-> trace_rec.seq == pipe_pkg::seq_t'(last_seq + 1'b1))
        else begin
            fail_cnt++;
            $error("trace seq %h does not follow %h", trace_rec.seq, last_seq);
        end

endmodule

// File: design/mini_pipe_top.sv
////////////////////////////////////////////////////////////////////////////
// Mini pipeline top
// Five-step in-order integer pipeline with a retire trace output
// fetch, decode, execute, memory, retire, valid/ready between each
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "pipe_macros.svh"

module mini_pipe_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  logic [`PIPE_ILEN-1:0] in_word,
    output logic                  trace_valid,
    input  logic                  trace_ready,
    output pipe_pkg::trace_rec_t  trace_rec
);

    ////////////////////////////////////////////////////////////////////////////
    // Stage links
    ////////////////////////////////////////////////////////////////////////////

    logic                 f_valid, f_ready, fq_valid, fq_ready;
    pipe_pkg::fetch_pkt_t f_pkt, fq_pkt;
    logic                 d_valid, d_ready, dq_valid, dq_ready;
    pipe_pkg::dec_pkt_t   d_pkt, dq_pkt;
    logic                 x_valid, x_ready;
    pipe_pkg::exe_pkt_t   x_pkt;
    logic                 m_valid, m_ready;
    pipe_pkg::mem_pkt_t   m_pkt;

    // Write-back path into the register file and scoreboard
    logic                 wb_en;
    pipe_pkg::reg_addr_t  wb_addr;
    pipe_pkg::data_t      wb_data;

    fetch_unit fetch_i (
        .clk (clk), .rst_n (rst_n),
        .in_valid  (in_valid), .in_ready  (in_ready), .in_word (in_word),
        .out_valid (f_valid),  .out_ready (f_ready),  .out_pkt (f_pkt)
    );

    pipe_stage_reg #(.payload_t(pipe_pkg::fetch_pkt_t)) fetch_reg_i (
        .clk (clk), .rst_n (rst_n),
        .in_valid  (f_valid),  .in_ready  (f_ready),  .in_data  (f_pkt),
        .out_valid (fq_valid), .out_ready (fq_ready), .out_data (fq_pkt)
    );

    decode_unit decode_i (
        .clk (clk), .rst_n (rst_n),
        .in_valid  (fq_valid), .in_ready  (fq_ready), .in_pkt  (fq_pkt),
        .out_valid (d_valid),  .out_ready (d_ready),  .out_pkt (d_pkt),
        .wr_en (wb_en), .wr_addr (wb_addr), .wr_data (wb_data)
    );

    pipe_stage_reg #(.payload_t(pipe_pkg::dec_pkt_t)) dec_reg_i (
        .clk (clk), .rst_n (rst_n),
        .in_valid  (d_valid),  .in_ready  (d_ready),  .in_data  (d_pkt),
        .out_valid (dq_valid), .out_ready (dq_ready), .out_data (dq_pkt)
    );

    execute_unit execute_i (
        .clk (clk), .rst_n (rst_n),
        .in_valid  (dq_valid), .in_ready  (dq_ready), .in_pkt  (dq_pkt),
        .out_valid (x_valid),  .out_ready (x_ready),  .out_pkt (x_pkt)
    );

    memory_unit memory_i (
        .clk (clk), .rst_n (rst_n),
        .in_valid  (x_valid), .in_ready  (x_ready), .in_pkt  (x_pkt),
        .out_valid (m_valid), .out_ready (m_ready), .out_pkt (m_pkt)
    );

    retire_trace_unit retire_i (
        .clk (clk), .rst_n (rst_n),
        .in_valid (m_valid), .in_ready (m_ready), .in_pkt (m_pkt),
        .wr_en (wb_en), .wr_addr (wb_addr), .wr_data (wb_data),
        .trace_valid (trace_valid), .trace_ready (trace_ready),
        .trace_rec   (trace_rec)
    );

endmodule

// File: design/retire_trace_unit.sv
////////////////////////////////////////////////////////////////////////////
// Retire trace unit
// Writes results back to the register file and emits one trace record
// per instruction, in program order, held until taken
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "pipe_macros.svh"

module retire_trace_unit (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  pipe_pkg::mem_pkt_t    in_pkt,
    output logic                  wr_en,
    output pipe_pkg::reg_addr_t   wr_addr,
    output logic [`PIPE_XLEN-1:0] wr_data,
    output logic                  trace_valid,
    input  logic                  trace_ready,
    output pipe_pkg::trace_rec_t  trace_rec
);

    logic                 retire;
    pipe_pkg::trace_rec_t rec_next;

    assign in_ready = !trace_valid || trace_ready;  // Record slot free or leaving
    assign retire   = in_valid && in_ready;

    // Write-back on the same edge the record loads
    assign wr_en   = retire && in_pkt.we;
    assign wr_addr = in_pkt.rd;
    assign wr_data = in_pkt.result;

    assign rec_next = '{seq: in_pkt.seq, pc: in_pkt.pc, opcode: in_pkt.opcode,
                        rd: in_pkt.rd, result: in_pkt.result, wrote: in_pkt.we,
                        stall_cnt: in_pkt.stall_cnt};

    ////////////////////////////////////////////////////////////////////////////
    // Output record register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            trace_valid <= 1'b0;
        end else if (retire) begin
            trace_valid <= 1'b1;
        end else if (trace_ready) begin
            trace_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (retire) begin
            trace_rec <= rec_next;  // Stable while waiting on trace_ready
        end
    end

endmodule

// File: design/memory_unit.sv
////////////////////////////////////////////////////////////////////////////
// Memory unit
// Data memory, asynchronous read and write on the accepting edge
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "pipe_macros.svh"

module memory_unit (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    output logic               in_ready,
    input  pipe_pkg::exe_pkt_t in_pkt,
    output logic               out_valid,
    input  logic               out_ready,
    output pipe_pkg::mem_pkt_t out_pkt
);

    localparam int AW = $clog2(`PIPE_DMEM_DEPTH);

    pipe_pkg::data_t    dmem [`PIPE_DMEM_DEPTH];
    logic [AW-1:0]      addr;
    logic               st_take;
    pipe_pkg::mem_pkt_t mem_pkt;

    assign addr    = in_pkt.result[AW-1:0];
    assign st_take = in_valid && in_ready && (in_pkt.opcode == pipe_pkg::OP_STORE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `PIPE_DMEM_DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (st_take) begin
            dmem[addr] <= in_pkt.st_data;
        end
    end

    // LOAD swaps the address for the memory word
    assign mem_pkt = '{opcode: in_pkt.opcode, rd: in_pkt.rd,
                       result: (in_pkt.opcode == pipe_pkg::OP_LOAD) ? dmem[addr]
                                                                    : in_pkt.result,
                       we: in_pkt.we, pc: in_pkt.pc, seq: in_pkt.seq,
                       stall_cnt: in_pkt.stall_cnt};

    pipe_stage_reg #(.payload_t(pipe_pkg::mem_pkt_t)) mem_reg_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (mem_pkt),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_pkt)
    );

endmodule

// File: design/execute_unit.sv
////////////////////////////////////////////////////////////////////////////
// Execute unit
// ALU for ADD, SUB, XOR and ADDI, address calculation for LOAD and STORE,
// result registered in its own stage register
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "pipe_macros.svh"

module execute_unit (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    output logic               in_ready,
    input  pipe_pkg::dec_pkt_t in_pkt,
    output logic               out_valid,
    input  logic               out_ready,
    output pipe_pkg::exe_pkt_t out_pkt
);

    localparam int AW = $clog2(`PIPE_DMEM_DEPTH);

    pipe_pkg::data_t    imm_ext, sum_imm, result;
    pipe_pkg::exe_pkt_t exe_pkt;

    assign imm_ext = {{(`PIPE_XLEN-6){in_pkt.imm[5]}}, in_pkt.imm};  // Sign extend
    assign sum_imm = in_pkt.src_a + imm_ext;

    always_comb begin
        case (in_pkt.opcode)
            pipe_pkg::OP_ADD:   result = in_pkt.src_a + in_pkt.src_b;
            pipe_pkg::OP_SUB:   result = in_pkt.src_a - in_pkt.src_b;
            pipe_pkg::OP_XOR:   result = in_pkt.src_a ^ in_pkt.src_b;
            pipe_pkg::OP_ADDI:  result = sum_imm;
            pipe_pkg::OP_LOAD,
            pipe_pkg::OP_STORE: result = `PIPE_XLEN'(sum_imm[AW-1:0]);  // Wraps on depth
            default:            result = '0;
        endcase
    end

    assign exe_pkt = '{opcode: in_pkt.opcode, rd: in_pkt.rd, result: result,
                       st_data: in_pkt.src_b, we: in_pkt.we, pc: in_pkt.pc,
                       seq: in_pkt.seq, stall_cnt: in_pkt.stall_cnt};

    pipe_stage_reg #(.payload_t(pipe_pkg::exe_pkt_t)) exe_reg_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (exe_pkt),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_pkt)
    );

endmodule

// File: design/decode_unit.sv
////////////////////////////////////////////////////////////////////////////
// Decode unit
// Splits the instruction fields, reads the register file and holds the
// instruction while an older one still owes a source or the destination
// Counts the held cycles, saturating
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "pipe_macros.svh"

module decode_unit (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  pipe_pkg::fetch_pkt_t  in_pkt,
    output logic                  out_valid,
    input  logic                  out_ready,
    output pipe_pkg::dec_pkt_t    out_pkt,
    input  logic                  wr_en,
    input  pipe_pkg::reg_addr_t   wr_addr,
    input  logic [`PIPE_XLEN-1:0] wr_data
);

    pipe_pkg::instr_fields_t f;
    pipe_pkg::reg_addr_t     b_addr;
    pipe_pkg::data_t         regs [`PIPE_NREGS];
    logic [`PIPE_NREGS-1:0]  pending;    // Scoreboard, one bit per register
    pipe_pkg::stall_t        stall_cnt;
    logic                    uses_a, uses_b, writes_rd, we, hazard, issue;

    assign f = pipe_pkg::instr_fields_t'(in_pkt.word);

    always_comb begin
        uses_a    = 1'b0;
        uses_b    = 1'b0;
        writes_rd = 1'b0;
        case (f.opcode)
            pipe_pkg::OP_ADD, pipe_pkg::OP_SUB, pipe_pkg::OP_XOR: begin
                uses_a    = 1'b1;
                uses_b    = 1'b1;
                writes_rd = 1'b1;
            end
            pipe_pkg::OP_ADDI, pipe_pkg::OP_LOAD: begin
                uses_a    = 1'b1;
                writes_rd = 1'b1;
            end
            pipe_pkg::OP_STORE: begin
                uses_a = 1'b1;
                uses_b = 1'b1;                        // Store data from rd
            end
            default: ;                                // NOP and unused codes
        endcase
    end

    assign b_addr = (f.opcode == pipe_pkg::OP_STORE) ? f.rd : f.rs2_imm[2:0];
    assign we     = writes_rd && (f.rd != '0);        // r0 writes are dropped

    // RAW on either source, WAW on rd so a clear never belongs to a newer write
    assign hazard = in_valid && ((uses_a && pending[f.rs1]) ||
                                 (uses_b && pending[b_addr]) ||
                                 (we && pending[f.rd]));
    assign in_ready  = out_ready && !hazard;
    assign out_valid = in_valid && !hazard;
    assign issue     = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `PIPE_NREGS; i++) begin
                regs[i] <= '0;
            end
            pending <= '0;
        end else begin
            if (wr_en && wr_addr != '0) begin
                regs[wr_addr] <= wr_data;
            end
            // Clear on write-back, set on issue, never the same bit
            pending <= (pending & ~(wr_en ? `PIPE_NREGS'(1) << wr_addr : '0))
                     | ((issue && we) ? `PIPE_NREGS'(1) << f.rd : '0);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || issue) begin
            stall_cnt <= '0;                          // Fresh count per instruction
        end else if (hazard && stall_cnt != '1) begin
            stall_cnt <= stall_cnt + 1'b1;
        end
    end

    assign out_pkt = '{opcode: f.opcode, rd: f.rd, src_a: regs[f.rs1],
                       src_b: regs[b_addr], imm: f.rs2_imm, we: we,
                       pc: in_pkt.pc, seq: in_pkt.seq, stall_cnt: stall_cnt};

endmodule

// File: design/fetch_unit.sv
////////////////////////////////////////////////////////////////////////////
// Fetch unit
// Takes instruction words from the input stream and tags each one
// with its pc and sequence id
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "pipe_macros.svh"

module fetch_unit (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  logic [`PIPE_ILEN-1:0] in_word,
    output logic                 out_valid,
    input  logic                 out_ready,
    output pipe_pkg::fetch_pkt_t out_pkt
);

    logic           en;   // Low for the first cycle after reset
    logic           take;
    pipe_pkg::pc_t  pc;
    pipe_pkg::seq_t seq;

    assign in_ready  = en && out_ready;
    assign out_valid = en && in_valid;
    assign take      = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            en  <= 1'b0;
            pc  <= '0;
            seq <= '0;
        end else begin
            en <= 1'b1;
            if (take) begin
                pc  <= pc + 1'b1;   // One word per pc step
                seq <= seq + 1'b1;
            end
        end
    end

    assign out_pkt = '{word: in_word, pc: pc, seq: seq};

endmodule

// File: design/pipe_stage_reg.sv
////////////////////////////////////////////////////////////////////////////
// Pipeline stage register
// One-entry valid/ready buffer for any packed payload, fills while draining
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module pipe_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic load;

    assign in_ready = !out_valid || out_ready;  // Empty, or entry leaving now
    assign load     = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (load) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;                  // Drained with nothing behind
        end
    end

    // Payload only moves with a transfer
    always_ff @(posedge clk) begin
        if (load) begin
            out_data <= in_data;
        end
    end

endmodule

// File: design/pipe_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Pipeline package
// Opcode encoding and the packed records handed from stage to stage
////////////////////////////////////////////////////////////////////////////

`include "pipe_macros.svh"

package pipe_pkg;

    typedef enum logic [3:0] {
        OP_NOP   = 4'h0,
        OP_ADD   = 4'h1,
        OP_SUB   = 4'h2,
        OP_XOR   = 4'h3,
        OP_ADDI  = 4'h4,  // rd = rs1 + imm
        OP_LOAD  = 4'h5,  // rd = mem[rs1 + imm]
        OP_STORE = 4'h6   // mem[rs1 + imm] = rd
    } opcode_e;

    typedef logic [`PIPE_XLEN-1:0]             data_t;
    typedef logic [`PIPE_ILEN-1:0]             instr_t;
    typedef logic [$clog2(`PIPE_NREGS)-1:0]    reg_addr_t;
    typedef logic [`PIPE_PC_W-1:0]             pc_t;
    typedef logic [`PIPE_SEQ_W-1:0]            seq_t;
    typedef logic [`PIPE_STALL_W-1:0]          stall_t;
    typedef logic signed [5:0]                 imm_t;

    // Instruction word layout, msb first
    typedef struct packed {
        opcode_e   opcode;
        reg_addr_t rd;
        reg_addr_t rs1;
        logic [5:0] rs2_imm;  // rs2 in the low three bits, or imm
    } instr_fields_t;

    typedef struct packed {
        instr_t word;
        pc_t    pc;
        seq_t   seq;
    } fetch_pkt_t;

    typedef struct packed {
        opcode_e   opcode;
        reg_addr_t rd;
        data_t     src_a;     // rs1 value
        data_t     src_b;     // rs2 value, or rd value for STORE
        imm_t      imm;
        logic      we;
        pc_t       pc;
        seq_t      seq;
        stall_t    stall_cnt;
    } dec_pkt_t;

    typedef struct packed {
        opcode_e   opcode;
        reg_addr_t rd;
        data_t     result;    // ALU result or memory address
        data_t     st_data;
        logic      we;
        pc_t       pc;
        seq_t      seq;
        stall_t    stall_cnt;
    } exe_pkt_t;

    typedef struct packed {
        opcode_e   opcode;
        reg_addr_t rd;
        data_t     result;
        logic      we;
        pc_t       pc;
        seq_t      seq;
        stall_t    stall_cnt;
    } mem_pkt_t;

    // Retire trace output record
    typedef struct packed {
        seq_t      seq;
        pc_t       pc;
        opcode_e   opcode;
        reg_addr_t rd;
        data_t     result;
        logic      wrote;     // Register file was written
        stall_t    stall_cnt;
    } trace_rec_t;

endpackage

// File: design/pipe_macros.svh
////////////////////////////////////////////////////////////////////////////
// Pipeline sizes
// Widths and depths shared by the package, the RTL and the testbench
////////////////////////////////////////////////////////////////////////////

`ifndef PIPE_MACROS_SVH
`define PIPE_MACROS_SVH

`define PIPE_XLEN        16  // Data and register width
`define PIPE_ILEN        16  // Instruction word width
`define PIPE_PC_W        8   // Program counter width
`define PIPE_NREGS       8   // Register file entries, r0 is hardwired zero
`define PIPE_DMEM_DEPTH  16  // Data memory words, power of two

// Tracking fields carried with each instruction
`define PIPE_SEQ_W       8   // Sequence id width, wraps
`define PIPE_STALL_W     4   // Saturating stall counter width

`endif
